//--- files.f
+incdir+.
cpuPkg.sv
dpCtrlIf.sv
regFile.sv
alu.sv
datapath.sv
controlUnit.sv
cpuTop.sv
cpuTop_sva.sv
cpuTop_tb.sv

//--- Bender.yml
package:
  name: cpuCore

export_include_dirs:
  - .

sources:
  - files:
      - cpuPkg.sv
      - dpCtrlIf.sv
      - regFile.sv
      - alu.sv
      - datapath.sv
      - controlUnit.sv
      - cpuTop.sv
  - target: simulation
    files:
      - cpuTop_sva.sv
      - cpuTop_tb.sv

//--- cpuTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module cpuTop_tb;
    import cpuPkg::*;

    localparam int MemWords = 256;
    localparam int MaxWait  = 3;
    localparam logic [31:0] Seed = 32'ha838;

    logic                   Clock;
    logic                   arstN;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   wbWe;
    logic [`DATA_WIDTH-1:0] wbAdr;
    logic [`DATA_WIDTH-1:0] wbDatW;
    logic [`DATA_WIDTH-1:0] wbDatR;
    logic                   wbAck;
    logic                   halted;

    logic [31:0] mem [MemWords];
    logic [31:0] refMem [MemWords];
    logic [31:0] expAdr [$];
    logic [31:0] expData [$];
    instrT       expInstr [$];
    int          progLen = 0;
    int          storeIdx = 0;
    int          cycleLimit = 0;
    logic        busy = 1'b0;
    int          waitLeft = 0;

    cpuTop uut (
        .Clock  (Clock),
        .arstN  (arstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .halted (halted)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run aborted at first error");
    endtask

    task automatic compareWord(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic expectInstr(input instrT got, input instrT exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0d ns: store from instruction %h, expected %h",
                               $time, got, exp));
        end
    endtask

    function automatic logic [31:0] encode(input opcodeT op, input int ra, input int rb,
                                           input int rc, input int imm);
        instrT ins;
        ins.opcode = op;
        ins.ra     = 4'(ra);
        ins.rb     = 4'(rb);
        ins.rc     = 4'(rc);
        ins.imm15  = 15'(imm);
        return ins;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[progLen] = word;
        progLen++;
    endtask

    // Instruction level model of the program running on a copy of memory
    function automatic void refRun();
        logic [31:0] regs [`REG_COUNT];
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [63:0] full;
        logic [31:0] zHigh;
        instrT       ins;
        pc     = `RESET_PC;
        zHigh  = '0;
        refMem = mem;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        for (int step = 0; step < 1000; step++) begin
            ins  = instrT'(refMem[pc[9:2]]);
            a    = regs[ins.ra];
            b    = regs[ins.rb];
            imm  = {{17{ins.imm15[14]}}, ins.imm15};
            addr = a + imm;
            pc   = pc + 4;
            full = '0;
            case (ins.opcode)
                OpAdd:  full[31:0] = a + b;
                OpSub:  full[31:0] = a - b;
                OpAnd:  full[31:0] = a & b;
                OpOr:   full[31:0] = a | b;
                OpXor:  full[31:0] = a ^ b;
                OpShl:  full[31:0] = a << b[4:0];
                OpShr:  full[31:0] = a >> b[4:0];
                OpMul:  full = {32'b0, a} * {32'b0, b};
                OpMfhi: full[31:0] = zHigh;
                OpAddi: full[31:0] = addr;
                OpLd:   full[31:0] = refMem[addr[9:2]];
                OpSt: begin
                    refMem[addr[9:2]] = b;
                    expAdr.push_back(addr);
                    expData.push_back(b);
                    expInstr.push_back(ins);
                end
                OpBrz: begin
                    if (a == '0) begin
                        pc = pc + (imm << 2);
                    end
                end
                default: return;
            endcase
            // Everything that goes through the ALU leaves its upper word in ZHigh
            if (ins.opcode != OpMfhi && ins.opcode != OpBrz) begin
                zHigh = full[63:32];
            end
            if (ins.opcode != OpSt && ins.opcode != OpBrz && ins.rc != 0) begin
                regs[ins.rc] = full[31:0];
            end
        end
    endfunction

    // Wishbone slave model driven on the falling edge
    always @(negedge Clock) begin
        if (wbAck) begin
            wbAck = 1'b0;
            busy  = 1'b0;
        end else if (arstN && wbCyc && wbStb) begin
            if (!busy) begin
                busy     = 1'b1;
                waitLeft = $urandom % (MaxWait + 1);
            end
            if (waitLeft == 0) begin
                if (wbWe) begin
                    mem[wbAdr[9:2]] = wbDatW;
                end else begin
                    wbDatR = mem[wbAdr[9:2]];
                end
                wbAck = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    // Store monitor
    // A write completes on the edge that sees the ack
    always @(posedge Clock) begin
        if (halted && wbCyc) begin
            abortRun("a bus cycle started after the core halted");
        end else if (arstN && wbCyc && wbStb && wbAck && wbWe) begin
            if (storeIdx >= expAdr.size()) begin
                abortRun("the core stored more words than the program predicts");
            end else begin
                expectInstr(uut.dpCtrl.instr, expInstr[storeIdx]);
                compareWord("store address", wbAdr, expAdr[storeIdx]);
                compareWord("store data", wbDatW, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    initial begin
        wait (cycleLimit > 0);
        repeat (cycleLimit) @(posedge Clock);
        abortRun($sformatf("timeout: the core did not halt within %0d cycles", cycleLimit));
    end

    initial begin
        opcodeT rOps [8];
        int     off;
        void'($urandom(Seed));
        arstN  = 1'b0;
        wbAck  = 1'b0;
        wbDatR = '0;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = $urandom;
        end
        // Operand r2 must be nonzero for the untaken branch
        mem[128] = mem[128] | 32'h1;
        rOps = '{OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl, OpShr, OpMul};

        // Base pointer and three loaded operands, then the OR case
        emit(encode(OpAddi, 0, 0, 1, 'h200));
        emit(encode(OpLd, 1, 0, 2, 0));
        emit(encode(OpLd, 1, 0, 3, 4));
        emit(encode(OpLd, 1, 0, 4, 8));
        emit(encode(OpOr, 2, 3, 5, 0));
        emit(encode(OpOr, 5, 4, 5, 0));
        emit(encode(OpSt, 1, 5, 0, 'h40));
        off = 'h44;
        foreach (rOps[i]) begin
            emit(encode(rOps[i], 2, 3, 6, 0));
            // MFHI has to follow MUL directly
            if (rOps[i] == OpMul) begin
                emit(encode(OpMfhi, 0, 0, 7, 0));
            end
            emit(encode(OpSt, 1, 6, 0, off));
            off += 4;
        end
        emit(encode(OpSt, 1, 7, 0, off));
        off += 4;
        // Negative immediates and offsets
        emit(encode(OpAddi, 2, 0, 8, -5));
        emit(encode(OpSt, 1, 8, 0, off));
        emit(encode(OpAddi, 1, 0, 9, 'h100));
        emit(encode(OpLd, 9, 0, 10, -'hF8));
        emit(encode(OpSt, 9, 10, 0, -4));
        // Taken branch skips a store and the untaken one falls through
        emit(encode(OpBrz, 0, 0, 0, 1));
        emit(encode(OpSt, 1, 2, 0, 'h1F0));
        emit(encode(OpBrz, 2, 0, 0, 1));
        emit(encode(OpSt, 1, 3, 0, 'h1F4));
        emit(encode(OpHalt, 0, 0, 0, 0));

        refRun();
        cycleLimit = progLen * 40 * MaxWait;

        repeat (3) @(posedge Clock);
        @(negedge Clock);
        arstN = 1'b1;

        while (!halted) begin
            @(negedge Clock);
        end
        repeat (10) @(negedge Clock);
        for (int i = 0; i < MemWords; i++) begin
            compareWord($sformatf("final mem[%0d]", i), mem[i], refMem[i]);
        end
        if (storeIdx != expAdr.size()) begin
            abortRun($sformatf("only %0d of %0d predicted stores were seen",
                               storeIdx, expAdr.size()));
        end else if (uut.ctrlUnit.busChecks.failCount != 0) begin
            abortRun("a bus or control assertion failed during the run");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end
endmodule

`default_nettype wire

//--- cpuTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_sva (
    input wire Clock,
    input wire arstN,
    input wire wbCyc,
    input wire wbStb,
    input wire wbWe,
    input wire wbAck,
    input wire halted,
    input wire adrPcSel,
    input wire pcEn,
    input wire zEn,
    input wire regWrite
);
    int failCount = 0;

    // A strobe never directly follows an acked cycle
    stbNeedsCyc: assert property (@(posedge Clock) disable iff (!arstN)
        wbStb |-> wbCyc && !$past(wbStb && wbAck))
        else begin
            $error("wbStb high without wbCyc or right after an acked cycle");
            failCount++;
        end

    // Request, direction and address source hold until the ack
    reqHeld: assert property (@(posedge Clock) disable iff (!arstN)
        (wbStb && !wbAck) |=> wbStb && $stable(wbWe) && $stable(adrPcSel))
        else begin
            $error("bus request changed before wbAck");
            failCount++;
        end

    // Neither PC nor ZLow loads while a request waits
    adrRegsHeld: assert property (@(posedge Clock) disable iff (!arstN)
        (wbStb && !wbAck) |-> !pcEn && !zEn)
        else begin
            $error("address register loaded before wbAck");
            failCount++;
        end

    // Halt is sticky and never writes a register
    noWriteHalted: assert property (@(posedge Clock) disable iff (!arstN)
        halted |=> halted && !regWrite)
        else begin
            $error("halted dropped or register written while halted");
            failCount++;
        end
endmodule

bind controlUnit cpuTop_sva busChecks (
    .Clock    (Clock),
    .arstN    (arstN),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAck    (wbAck),
    .halted   (halted),
    .adrPcSel (ctl.adrPcSel),
    .pcEn     (ctl.pcEn),
    .zEn      (ctl.zEn),
    .regWrite (ctl.regWrite)
);

`default_nettype wire

//--- cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module cpuTop (
    input  wire                     Clock,
    input  wire                     arstN,
    // Wishbone classic master
    output logic                    wbCyc,
    output logic                    wbStb,
    output logic                    wbWe,
    output logic [`DATA_WIDTH-1:0]  wbAdr,
    output logic [`DATA_WIDTH-1:0]  wbDatW,
    input  wire  [`DATA_WIDTH-1:0]  wbDatR,
    input  wire                     wbAck,
    output logic                    halted
);
    dpCtrlIf dpCtrl ();

    controlUnit ctrlUnit (
        .Clock  (Clock),
        .arstN  (arstN),
        .ctl    (dpCtrl.ctrl),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAck  (wbAck),
        .halted (halted)
    );

    // Address and store data come straight from the datapath registers
    datapath dp (
        .Clock    (Clock),
        .arstN    (arstN),
        .ctl      (dpCtrl.dp),
        .memRdata (wbDatR),
        .memAdr   (wbAdr),
        .memWdata (wbDatW)
    );
endmodule

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire     Clock,
    input  wire     arstN,
    dpCtrlIf.ctrl   ctl,
    output logic    wbCyc,
    output logic    wbStb,
    output logic    wbWe,
    input  wire     wbAck,
    output logic    halted
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        Fetch, Decode, Execute, Memory, WriteA, WriteB, Halt
    } stateT;

    stateT  state;
    opcodeT op;
    logic   busReq;
    logic   busDone;
    logic   usesImm;
    logic   isDefined;

    assign op      = ctl.instr.opcode;
    assign busDone = busReq && wbAck;
    assign usesImm = (op == OpAddi) || (op == OpLd) || (op == OpSt);

    always_comb begin
        case (op)
            OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl, OpShr, OpMul,
            OpMfhi, OpAddi, OpLd, OpSt, OpBrz: isDefined = 1'b1;
            default: isDefined = 1'b0;
        endcase
    end

    // Bus request is registered so it drops on the edge after the ack
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state  <= Fetch;
            busReq <= 1'b0;
            wbWe   <= 1'b0;
        end else begin
            case (state)
                Fetch: begin
                    if (!busReq) begin
                        busReq <= 1'b1;
                    end else if (wbAck) begin
                        busReq <= 1'b0;
                        state  <= Decode;
                    end
                end
                Decode: state <= isDefined ? Execute : Halt;
                Execute: begin
                    if (op == OpLd || op == OpSt) begin
                        busReq <= 1'b1;
                        wbWe   <= (op == OpSt);
                        state  <= Memory;
                    end else if (op == OpBrz) begin
                        busReq <= 1'b1;
                        state  <= Fetch;
                    end else begin
                        state <= WriteA;
                    end
                end
                Memory: begin
                    if (wbAck) begin
                        busReq <= 1'b0;
                        wbWe   <= 1'b0;
                        state  <= (op == OpLd) ? WriteB : Fetch;
                    end
                end
                WriteA: state <= WriteB;
                WriteB: begin
                    busReq <= 1'b1;
                    state  <= Fetch;
                end
                default: state <= Halt;
            endcase
        end
    end

    assign ctl.regAddrA = ctl.instr.ra;
    assign ctl.regAddrB = ctl.instr.rb;
    assign ctl.regAddrC = ctl.instr.rc;
    assign ctl.aluOp    = aluOpFor(op);

    always_comb begin
        ctl.pcEn     = 1'b0;
        ctl.pcBranch = 1'b0;
        ctl.irEn     = 1'b0;
        ctl.regWrite = 1'b0;
        ctl.aEn      = 1'b0;
        ctl.bEn      = 1'b0;
        ctl.bImmSel  = 1'b0;
        ctl.zEn      = 1'b0;
        ctl.hiSel    = 1'b0;
        ctl.wbEn     = 1'b0;
        ctl.wbMemSel = 1'b0;
        ctl.adrPcSel = 1'b0;
        case (state)
            Fetch: begin
                ctl.adrPcSel = 1'b1;
                ctl.irEn     = busDone;
                ctl.pcEn     = busDone;
            end
            Decode: begin
                ctl.aEn     = 1'b1;
                ctl.bEn     = 1'b1;
                ctl.bImmSel = usesImm;
            end
            Execute: begin
                ctl.zEn = (op != OpMfhi) && (op != OpBrz);
                // ST swaps the immediate in B for the store data
                ctl.bEn = (op == OpSt);
                if (op == OpBrz) begin
                    ctl.pcEn     = ctl.aZero;
                    ctl.pcBranch = 1'b1;
                end
            end
            Memory: begin
                ctl.wbMemSel = 1'b1;
                ctl.wbEn     = busDone && (op == OpLd);
            end
            WriteA: begin
                ctl.wbEn  = 1'b1;
                ctl.hiSel = (op == OpMfhi);
            end
            WriteB: ctl.regWrite = 1'b1;
            default: ;
        endcase
    end

    assign wbCyc  = busReq;
    assign wbStb  = busReq;
    assign halted = (state == Halt);
endmodule

`default_nettype wire

//--- datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module datapath (
    input  wire                     Clock,
    input  wire                     arstN,
    dpCtrlIf.dp                     ctl,
    input  wire  [`DATA_WIDTH-1:0]  memRdata,
    output logic [`DATA_WIDTH-1:0]  memAdr,
    output logic [`DATA_WIDTH-1:0]  memWdata
);
    import cpuPkg::*;

    localparam int W = `DATA_WIDTH;

    logic [W-1:0]   pc;
    instrT          ir;
    logic [W-1:0]   aReg;
    logic [W-1:0]   bReg;
    logic [W-1:0]   zHigh;
    logic [W-1:0]   zLow;
    logic [W-1:0]   wbReg;
    logic [W-1:0]   rfA;
    logic [W-1:0]   rfB;
    logic [W-1:0]   imm32;
    logic [2*W-1:0] aluResult;

    assign imm32 = {{(W-15){ir.imm15[14]}}, ir.imm15};

    regFile rf (
        .Clock (Clock),
        .arstN (arstN),
        .addrA (ctl.regAddrA),
        .addrB (ctl.regAddrB),
        .addrC (ctl.regAddrC),
        .write (ctl.regWrite),
        .dataC (wbReg),
        .dataA (rfA),
        .dataB (rfB)
    );

    alu aluInst (
        .op     (ctl.aluOp),
        .a      (aReg),
        .b      (bReg),
        .result (aluResult),
        .zero   (),
        .neg    ()
    );

    // PC already points past the branch when the offset is added
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (ctl.pcEn) begin
            pc <= ctl.pcBranch ? pc + {imm32[W-3:0], 2'b00} : pc + W'(4);
        end
    end

    always_ff @(posedge Clock) begin
        if (ctl.irEn) begin
            ir <= instrT'(memRdata);
        end
        if (ctl.aEn) begin
            aReg <= rfA;
        end
        if (ctl.bEn) begin
            bReg <= ctl.bImmSel ? imm32 : rfB;
        end
        if (ctl.zEn) begin
            zHigh <= aluResult[2*W-1:W];
            zLow  <= aluResult[W-1:0];
        end
        // Write-back source is memory or one half of Z
        if (ctl.wbEn) begin
            wbReg <= ctl.wbMemSel ? memRdata : (ctl.hiSel ? zHigh : zLow);
        end
    end

    assign memAdr    = ctl.adrPcSel ? pc : zLow;
    assign memWdata  = bReg;
    assign ctl.instr = ir;
    assign ctl.aZero = (aReg == '0);
endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module alu (
    input  wire cpuPkg::aluOpT          op,
    input  wire  [`DATA_WIDTH-1:0]      a,
    input  wire  [`DATA_WIDTH-1:0]      b,
    output logic [2*`DATA_WIDTH-1:0]    result,
    output logic                        zero,
    output logic                        neg
);
    import cpuPkg::*;

    localparam int W = `DATA_WIDTH;
    localparam int ShW = $clog2(W);

    logic [ShW-1:0] shAmt;

    // Shift distance comes from the low bits of b only
    assign shAmt = b[ShW-1:0];

    always_comb begin
        result = '0;
        case (op)
            AluAdd:   result[W-1:0] = a + b;
            AluSub:   result[W-1:0] = a - b;
            AluAnd:   result[W-1:0] = a & b;
            AluOr:    result[W-1:0] = a | b;
            AluXor:   result[W-1:0] = a ^ b;
            AluShl:   result[W-1:0] = a << shAmt;
            AluShr:   result[W-1:0] = a >> shAmt;
            // Unsigned full product with the upper word going to ZHigh
            AluMul:   result = (2*W)'(a) * (2*W)'(b);
            AluPassB: result[W-1:0] = b;
            default:  result = '0;
        endcase
    end

    // Flags look at the low word
    assign zero = (result[W-1:0] == '0);
    assign neg  = result[W-1];
endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module regFile (
    input  wire                                Clock,
    input  wire                                arstN,
    input  wire  [$clog2(`REG_COUNT)-1:0]      addrA,
    input  wire  [$clog2(`REG_COUNT)-1:0]      addrB,
    input  wire  [$clog2(`REG_COUNT)-1:0]      addrC,
    input  wire                                write,
    input  wire  [`DATA_WIDTH-1:0]             dataC,
    output logic [`DATA_WIDTH-1:0]             dataA,
    output logic [`DATA_WIDTH-1:0]             dataB
);
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // All registers start out as zero
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (addrC != '0)) begin
            regs[addrC] <= dataC;
        end
    end

    // R0 is hardwired to zero
    assign dataA = (addrA == '0) ? '0 : regs[addrA];
    assign dataB = (addrB == '0) ? '0 : regs[addrB];
endmodule

`default_nettype wire

//--- dpCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

interface dpCtrlIf;
    import cpuPkg::*;

    localparam int RegAddrW = $clog2(`REG_COUNT);

    // Control unit to datapath
    logic                pcEn;
    logic                pcBranch;
    logic                irEn;
    logic [RegAddrW-1:0] regAddrA;
    logic [RegAddrW-1:0] regAddrB;
    logic [RegAddrW-1:0] regAddrC;
    logic                regWrite;
    logic                aEn;
    logic                bEn;
    logic                bImmSel;
    logic                zEn;
    aluOpT               aluOp;
    logic                hiSel;
    logic                wbEn;
    logic                wbMemSel;
    logic                adrPcSel;

    // Datapath status back to the control unit
    instrT               instr;
    logic                aZero;

    modport ctrl (
        output pcEn, pcBranch, irEn,
        output regAddrA, regAddrB, regAddrC, regWrite,
        output aEn, bEn, bImmSel, zEn, aluOp,
        output hiSel, wbEn, wbMemSel, adrPcSel,
        input  instr, aZero
    );

    modport dp (
        input  pcEn, pcBranch, irEn,
        input  regAddrA, regAddrB, regAddrC, regWrite,
        input  aEn, bEn, bImmSel, zEn, aluOp,
        input  hiSel, wbEn, wbMemSel, adrPcSel,
        output instr, aZero
    );
endinterface

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Instruction opcodes
    // Anything not listed here halts the core
    typedef enum logic [4:0] {
        OpAdd  = 5'h00,
        OpSub  = 5'h01,
        OpAnd  = 5'h02,
        OpOr   = 5'h03,
        OpXor  = 5'h04,
        OpShl  = 5'h05,
        OpShr  = 5'h06,
        OpMul  = 5'h07,
        OpMfhi = 5'h08,
        OpAddi = 5'h09,
        OpLd   = 5'h0A,
        OpSt   = 5'h0B,
        OpBrz  = 5'h0C,
        OpHalt = 5'h1F
    } opcodeT;

    typedef enum logic [3:0] {
        AluAdd   = 4'h0,
        AluSub   = 4'h1,
        AluAnd   = 4'h2,
        AluOr    = 4'h3,
        AluXor   = 4'h4,
        AluShl   = 4'h5,
        AluShr   = 4'h6,
        AluMul   = 4'h7,
        AluPassB = 4'h8
    } aluOpT;

    // Instruction word layout
    typedef struct packed {
        opcodeT      opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] imm15;
    } instrT;

    // Address arithmetic for ADDI, LD and ST goes through the adder
    function automatic aluOpT aluOpFor(input opcodeT op);
        case (op)
            OpAdd, OpAddi, OpLd, OpSt: return AluAdd;
            OpSub: return AluSub;
            OpAnd: return AluAnd;
            OpOr:  return AluOr;
            OpXor: return AluXor;
            OpShl: return AluShl;
            OpShr: return AluShr;
            OpMul: return AluMul;
            default: return AluPassB;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Word size of registers, ALU operands and the bus
`define DATA_WIDTH 32

// Register file depth, gives 4-bit register indices
`define REG_COUNT 16

// Address of the first instruction fetch
`define RESET_PC 32'h0000_0000

`endif
